/* Makefile */
TOOL       = verilator
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing --assert -Wall -Wno-fatal
TOP        = slowVramTb
FILELIST   = list.f
OBJ_DIR    = obj_dir
LOG        = sim.log
RUN_ARGS   = +verilator+error+limit+1000
FAIL_MSG   = Simulation FAILED
PASS_MSG   = Simulation PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Run failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Run ended without a result, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* cpuVramPort.sv */
`timescale 1ns/10ps

module cpuVramPort
	import slowVramPkg::*;
(
	input  logic      CLK_24M,
	input  logic      CYCLE_SLOW,
	input  logic      cpuValid,     // Costs one credit
	input  cpuOpT     cpuOp,
	input  vramDataT  cpuData,
	input  vramAddrT  cpuAddr,      // Address or modulo operand
	output logic      cpuCredit,    // One credit back per pop
	output logic      rdValid,
	output vramDataT  rdData,
	input  slotPhaseT slotPhase,
	slowVramIf.client bus
);

	// Command queue storage
	cpuOpT    qOp   [CPU_CREDITS];
	vramDataT qData [CPU_CREDITS];
	vramAddrT qAddr [CPU_CREDITS];

	logic [QUEUE_PTR_W:0]   head;     // Extra bit tells full from empty
	logic [QUEUE_PTR_W:0]   tail;
	logic [QUEUE_PTR_W-1:0] headIdx;
	logic [QUEUE_PTR_W-1:0] tailIdx;
	logic                   qEmpty;
	logic                   pop;
	cpuOpT                  headOp;

	vramAddrT curAddr;    // Auto-incrementing access address
	vramAddrT modulo;
	logic     rdPending;  // Read issued this frame

	assign headIdx = head[QUEUE_PTR_W-1:0];
	assign tailIdx = tail[QUEUE_PTR_W-1:0];
	assign qEmpty  = (head == tail);
	assign pop     = (slotPhase == PH_CPU) && !qEmpty;   // One command per frame
	assign headOp  = qOp[headIdx];

	// Bus only matters in the CPU slot
	assign bus.addr   = curAddr;
	assign bus.wrData = qData[headIdx];
	assign bus.wrEn   = pop && (headOp == opWrite);

	// Push, credits guarantee a free entry
	always_ff @(posedge CLK_24M)
	begin
		if (cpuValid)
		begin
			qOp[tailIdx]   <= cpuOp;
			qData[tailIdx] <= cpuData;
			qAddr[tailIdx] <= cpuAddr;
		end
	end

	always_ff @(posedge CLK_24M or posedge CYCLE_SLOW)
	begin
		if (CYCLE_SLOW)
		begin
			head      <= '0;
			tail      <= '0;
			curAddr   <= '0;
			modulo    <= '0;
			cpuCredit <= 1'b0;
			rdPending <= 1'b0;
			rdValid   <= 1'b0;
		end
		else
		begin
			if (cpuValid)
				tail <= tail + 1'b1;
			cpuCredit <= pop;                                     // Phase 5 pulse
			rdValid   <= rdPending && (slotPhase == PH_CPU_RD);  // Phase 6 pulse
			if (pop)
			begin
				head <= head + 1'b1;
				case (headOp)
					opSetAddr: curAddr <= qAddr[headIdx];
					opSetMod:  modulo  <= qAddr[headIdx];
					opWrite:   curAddr <= curAddr + modulo;    // Wraps at 15 bits
					opRead:    rdPending <= 1'b1;               // Address stays put
				endcase
			end
			else if (slotPhase == PH_CPU_RD)
				rdPending <= 1'b0;
		end
	end

	// Read word, registered by the RAM at end of phase 4
	always_ff @(posedge CLK_24M)
	begin
		if (rdPending && (slotPhase == PH_CPU_RD))
			rdData <= bus.rdData;
	end

endmodule

/* list.f */
slowVramPkg.sv
slowVramIf.sv
slowVramRam.sv
slowSlotArbiter.sv
cpuVramPort.sv
spriteFixFetch.sv
slowVramTop.sv
slowVram_assert.sv
slowVramTb.sv

/* slowSlotArbiter.sv */
`timescale 1ns/10ps

module slowSlotArbiter
	import slowVramPkg::*;
(
	input  logic       CLK_24M,
	input  logic       CYCLE_SLOW,
	slowVramIf.arbiter cpuBus,
	slowVramIf.arbiter sprBus,
	slowVramIf.arbiter fixBus,
	output slotPhaseT  slotPhase
);

	slotT slot;        // Current owner

	slowVramIf ramBus();

	slowVramRam ramInst
	(
		.CLK_24M (CLK_24M),
		.bus     (ramBus)
	);

	// Free-running frame counter
	always_ff @(posedge CLK_24M or posedge CYCLE_SLOW)
	begin
		if (CYCLE_SLOW)
			slotPhase <= '0;
		else if (slotPhase == slotPhaseT'(SLOT_FRAME - 1))
			slotPhase <= '0;                  // Wrap to sprite word A
		else
			slotPhase <= slotPhase + 3'd1;
	end

	assign slot = slotT'(slotPhase[2:1]);    // Two phases per slot

	// Owner drives the RAM, others are ignored
	always_comb
	begin
		ramBus.addr   = fixBus.addr;
		ramBus.wrData = fixBus.wrData;
		ramBus.wrEn   = fixBus.wrEn;
		case (slot)
			slotSprA, slotSprB:
			begin
				ramBus.addr   = sprBus.addr;
				ramBus.wrData = sprBus.wrData;
				ramBus.wrEn   = sprBus.wrEn;
			end
			slotCpu:
			begin
				ramBus.addr   = cpuBus.addr;
				ramBus.wrData = cpuBus.wrData;
				ramBus.wrEn   = cpuBus.wrEn;
			end
			default:
			begin
				// Fix slot, already the default
			end
		endcase
	end

	// Read word fans out, each client knows its own phase
	assign cpuBus.rdData = ramBus.rdData;
	assign sprBus.rdData = ramBus.rdData;
	assign fixBus.rdData = ramBus.rdData;

endmodule

/* slowVramIf.sv */
`timescale 1ns/10ps

// One client's view of the slow VRAM
interface slowVramIf
	import slowVramPkg::*;
();

	vramAddrT addr;     // Word address
	vramDataT wrData;
	logic     wrEn;     // Only honored in the owner's slot
	vramDataT rdData;   // Registered RAM output, shared

	modport client
	(
		output addr,
		output wrData,
		output wrEn,
		input  rdData
	);

	// Also the RAM side of the internal bus
	modport arbiter
	(
		input  addr,
		input  wrData,
		input  wrEn,
		output rdData
	);

endinterface

/* slowVramPkg.sv */
package slowVramPkg;

	typedef logic [14:0] vramAddrT;    // Slow VRAM word address
	typedef logic [15:0] vramDataT;    // One VRAM word
	typedef logic [2:0]  slotPhaseT;   // Position inside the slot frame

	// Sprite map addressing
	typedef logic [8:0]  sprNbT;
	typedef logic [4:0]  sprTileIdxT;

	// Fix map addressing
	typedef logic [5:0]  fixColT;
	typedef logic [4:0]  fixLineT;

	// Decoded tile numbers
	typedef logic [19:0] tileNbT;
	typedef logic [11:0] fixTileNbT;

	// Two phases per slot, fixed order
	typedef enum logic [1:0]
	{
		slotSprA = 2'd0,
		slotSprB = 2'd1,
		slotCpu  = 2'd2,
		slotFix  = 2'd3
	} slotT;

	typedef enum logic [1:0]
	{
		opSetAddr = 2'd0,
		opSetMod  = 2'd1,
		opWrite   = 2'd2,
		opRead    = 2'd3
	} cpuOpT;

	localparam int SLOT_FRAME  = 8;                      // Cycles per frame
	localparam int VRAM_WORDS  = 32768;
	localparam int CPU_CREDITS = 2;                      // Queue depth = initial credits
	localparam int QUEUE_PTR_W = $clog2(CPU_CREDITS);
	localparam logic [3:0] FIX_MAP_BASE = 4'b1110;       // Fix map lives at $7000

	// Phase markers within the frame
	localparam slotPhaseT PH_SPR_A       = 3'd0;         // Word A address, sprite inputs sampled
	localparam slotPhaseT PH_SPR_A_LATCH = 3'd1;
	localparam slotPhaseT PH_SPR_B       = 3'd2;         // Word B address
	localparam slotPhaseT PH_SPR_B_LATCH = 3'd3;
	localparam slotPhaseT PH_CPU         = 3'd4;         // Pop, write commit
	localparam slotPhaseT PH_CPU_RD      = 3'd5;         // CPU read word on the bus
	localparam slotPhaseT PH_FIX_LATCH   = 3'd7;

endpackage

/* slowVramRam.sv */
`timescale 1ns/10ps

// 32K x 16 slow VRAM, single port
module slowVramRam
	import slowVramPkg::*;
(
	input logic        CLK_24M,
	slowVramIf.arbiter bus
);

	vramDataT mem [VRAM_WORDS];    // Contents undefined at power up

	// Write port
	always_ff @(posedge CLK_24M)
	begin
		if (bus.wrEn)
			mem[bus.addr] <= bus.wrData;
	end

	// Registered read every cycle, old data on a write
	always_ff @(posedge CLK_24M)
	begin
		bus.rdData <= mem[bus.addr];
	end

endmodule

/* slowVramTb.sv */
`timescale 1ns/10ps

module slowVramTb
	import slowVramPkg::*;
();

	localparam int        CYCLE_LIMIT  = 4000;    // Tests need about 1300 cycles
	localparam slotPhaseT PH_FIX_INPUT = 3'd6;    // Fix inputs used here

	logic       CLK_24M;
	logic       CYCLE_SLOW;
	logic       cpuValid;
	cpuOpT      cpuOp;
	vramDataT   cpuData;
	vramAddrT   cpuAddr;
	logic       cpuCredit;
	logic       rdValid;
	vramDataT   rdData;
	sprNbT      sprNb;
	sprTileIdxT sprTileIdx;
	tileNbT     sprTileNb;
	logic [7:0] sprPal;
	logic [1:0] sprAutoAnim;
	logic [1:0] sprFlip;
	logic       sprValid;
	fixColT     fixCol;
	fixLineT    fixLine;
	fixTileNbT  fixTileNb;
	logic [3:0] fixPal;
	logic       fixValid;
	slotPhaseT  slotPhase;

	vramDataT    refMem [VRAM_WORDS];    // Reference VRAM contents
	vramAddrT    modelAddr;              // Mirror of the port's address register
	vramAddrT    modelMod;
	vramDataT    expRd [$];              // Reads in flight, oldest first
	int          credits;
	int          errCount;
	int          cycleCount;
	logic [31:0] lcgState;
	slotPhaseT   expPhase;

	slowVramTop slowVramTop_inst (.*);

	initial
		CLK_24M = 1'b0;
	always #50 CLK_24M = ~CLK_24M;    // 100 ns period

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	task automatic checkValue(input string what, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			errCount++;
			$display("FAIL at %0t: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	// One cycle, everything sampled on the falling edge
	task automatic tick();
		@(negedge CLK_24M);
		cpuValid = 1'b0;
		expPhase = expPhase + 3'd1;
		checkValue("slotPhase", 32'(slotPhase), 32'(expPhase));
		if (cpuCredit)
			credits++;
		assert (credits <= CPU_CREDITS)
		else
		begin
			errCount++;
			$display("Sender credit count rose above %0d: %0d", CPU_CREDITS, credits);
		end
		if (rdValid)
		begin
			if (expRd.size() == 0)
			begin
				errCount++;
				$display("Read data returned at %0t with no read outstanding", $time);
			end
			else
				checkValue("rdData", 32'(rdData), 32'(expRd.pop_front()));
		end
	endtask

	// Issue one command once a credit is held
	task automatic sendCmd(input cpuOpT op, input vramAddrT addr, input vramDataT data);
		tick();
		while (credits == 0)
			tick();
		cpuValid = 1'b1;
		cpuOp    = op;
		cpuAddr  = addr;
		cpuData  = data;
		credits--;
		case (op)
			opSetAddr: modelAddr = addr;
			opSetMod:  modelMod  = addr;
			opWrite:
			begin
				refMem[modelAddr] = data;
				modelAddr = modelAddr + modelMod;    // 15-bit wrap
			end
			default:   expRd.push_back(refMem[modelAddr]);
		endcase
	endtask

	task automatic writeWord(input vramAddrT addr, input vramDataT data);
		sendCmd(opSetAddr, addr, '0);
		sendCmd(opWrite, '0, data);
	endtask

	task automatic readWord(input vramAddrT addr);
		sendCmd(opSetAddr, addr, '0);
		sendCmd(opRead, '0, '0);
	endtask

	// Until all credits are back and all reads returned
	task automatic drainQueue();
		while (credits != CPU_CREDITS || expRd.size() != 0)
			tick();
	endtask

	task automatic checkSprite(input sprNbT nb, input sprTileIdxT idx);
		vramDataT wordA;
		vramDataT wordB;
		wordA = refMem[{nb, idx, 1'b0}];
		wordB = refMem[{nb, idx, 1'b1}];
		tick();
		sprNb      = nb;
		sprTileIdx = idx;
		tick();
		while (slotPhase != PH_SPR_A)    // Held through the sampling phase
			tick();
		tick();
		while (!sprValid)
			tick();
		checkValue("sprTileNb", 32'(sprTileNb), 32'({wordB[7:4], wordA}));
		checkValue("sprPal", 32'(sprPal), 32'(wordB[15:8]));
		checkValue("sprAutoAnim", 32'(sprAutoAnim), 32'(wordB[3:2]));
		checkValue("sprFlip", 32'(sprFlip), 32'(wordB[1:0]));
	endtask

	task automatic checkFix(input fixColT col, input fixLineT line);
		vramDataT word;
		word = refMem[{FIX_MAP_BASE, col, line}];
		tick();
		fixCol  = col;
		fixLine = line;
		tick();
		while (slotPhase != PH_FIX_INPUT)
			tick();
		tick();
		while (!fixValid)
			tick();
		checkValue("fixTileNb", 32'(fixTileNb), 32'(word[11:0]));
		checkValue("fixPal", 32'(fixPal), 32'(word[15:12]));
	endtask

	initial
	begin
		cycleCount = 0;
		while (cycleCount < CYCLE_LIMIT)
		begin
			@(posedge CLK_24M);
			cycleCount++;
		end
		$display("Timeout after %0d cycles, the tests did not finish", CYCLE_LIMIT);
		$display("Simulation FAILED");
		$finish;
	end

	initial
	begin
		vramAddrT   addrs [8];
		vramAddrT   base;
		vramAddrT   step;
		sprNbT      nbs [6];
		sprTileIdxT idxs [6];
		fixColT     cols [6];
		fixLineT    lines [6];
		int         assertErrors;
		CYCLE_SLOW  = 1'b1;
		cpuValid    = 1'b0;
		cpuOp       = opSetAddr;
		cpuData     = '0;
		cpuAddr     = '0;
		sprNb       = '0;
		sprTileIdx  = '0;
		fixCol      = '0;
		fixLine     = '0;
		lcgState    = 32'd22;
		credits     = CPU_CREDITS;
		errCount    = 0;
		modelAddr   = '0;
		modelMod    = '0;
		expPhase    = '0;

		// Reset, three rising edges
		repeat (3)
		begin
			@(negedge CLK_24M);
			checkValue("slotPhase in reset", 32'(slotPhase), 32'd0);
			checkValue("strobes in reset", 32'({cpuCredit, rdValid, sprValid, fixValid}), 32'd0);
		end
		CYCLE_SLOW = 1'b0;
		checkValue("slotPhase after reset", 32'(slotPhase), 32'd0);
		repeat (16)
		begin
			tick();
			checkValue("idle CPU strobes", 32'({cpuCredit, rdValid}), 32'd0);
		end

		// Write then read back, modulo 0
		sendCmd(opSetMod, '0, '0);
		for (int i = 0; i < 8; i++)
		begin
			addrs[i] = vramAddrT'(nextRand() >> 17);
			writeWord(addrs[i], vramDataT'(nextRand() >> 16));
		end
		for (int i = 0; i < 8; i++)
			readWord(addrs[i]);
		drainQueue();

		// Write bursts with a random modulo
		repeat (2)
		begin
			step = vramAddrT'(nextRand() >> 17);
			base = vramAddrT'(nextRand() >> 17);
			sendCmd(opSetMod, step, '0);
			sendCmd(opSetAddr, base, '0);
			for (int k = 0; k < 6; k++)
				sendCmd(opWrite, '0, vramDataT'(nextRand() >> 16));
			for (int k = 0; k < 6; k++)
				readWord(vramAddrT'(32'(base) + k * 32'(step)));
			drainQueue();
		end

		// Back to back stream, credits only
		sendCmd(opSetMod, '0, '0);
		for (int i = 0; i < 6; i++)
		begin
			base = vramAddrT'(nextRand() >> 17);
			writeWord(base, vramDataT'(nextRand() >> 16));
			readWord(base);
		end
		drainQueue();

		// Sprite map words A and B side by side
		sendCmd(opSetMod, 15'd1, '0);
		for (int i = 0; i < 6; i++)
		begin
			nbs[i]  = sprNbT'(nextRand() >> 23);
			idxs[i] = sprTileIdxT'(nextRand() >> 27);
			sendCmd(opSetAddr, {nbs[i], idxs[i], 1'b0}, '0);
			sendCmd(opWrite, '0, vramDataT'(nextRand() >> 16));
			sendCmd(opWrite, '0, vramDataT'(nextRand() >> 16));
		end
		drainQueue();
		for (int i = 0; i < 6; i++)
			checkSprite(nbs[i], idxs[i]);

		// Fix map words
		for (int i = 0; i < 6; i++)
		begin
			cols[i]  = fixColT'(nextRand() >> 26);
			lines[i] = fixLineT'(nextRand() >> 27);
			writeWord({FIX_MAP_BASE, cols[i], lines[i]}, vramDataT'(nextRand() >> 16));
		end
		drainQueue();
		for (int i = 0; i < 6; i++)
			checkFix(cols[i], lines[i]);

		tick();
		assertErrors = slowVramTop_inst.assertInst.failCount;
		$display("Errors: %0d check, %0d assertion", errCount, assertErrors);
		if (errCount == 0 && assertErrors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

/* slowVramTop.sv */
`timescale 1ns/10ps

module slowVramTop
	import slowVramPkg::*;
(
	input  logic       CLK_24M,
	input  logic       CYCLE_SLOW,
	// CPU command side
	input  logic       cpuValid,
	input  cpuOpT      cpuOp,
	input  vramDataT   cpuData,
	input  vramAddrT   cpuAddr,
	output logic       cpuCredit,
	output logic       rdValid,
	output vramDataT   rdData,
	// Sprite map fetch
	input  sprNbT      sprNb,
	input  sprTileIdxT sprTileIdx,
	output tileNbT     sprTileNb,
	output logic [7:0] sprPal,
	output logic [1:0] sprAutoAnim,
	output logic [1:0] sprFlip,
	output logic       sprValid,
	// Fix map fetch
	input  fixColT     fixCol,
	input  fixLineT    fixLine,
	output fixTileNbT  fixTileNb,
	output logic [3:0] fixPal,
	output logic       fixValid,
	output slotPhaseT  slotPhase    // Frame position, from the arbiter
);

	slowVramIf cpuBus();
	slowVramIf sprBus();
	slowVramIf fixBus();

	slowSlotArbiter arbiterInst
	(
		.CLK_24M    (CLK_24M),
		.CYCLE_SLOW (CYCLE_SLOW),
		.cpuBus     (cpuBus),
		.sprBus     (sprBus),
		.fixBus     (fixBus),
		.slotPhase  (slotPhase)
	);

	cpuVramPort cpuPortInst
	(
		.CLK_24M    (CLK_24M),
		.CYCLE_SLOW (CYCLE_SLOW),
		.cpuValid   (cpuValid),
		.cpuOp      (cpuOp),
		.cpuData    (cpuData),
		.cpuAddr    (cpuAddr),
		.cpuCredit  (cpuCredit),
		.rdValid    (rdValid),
		.rdData     (rdData),
		.slotPhase  (slotPhase),
		.bus        (cpuBus)
	);

	spriteFixFetch fetchInst
	(
		.CLK_24M     (CLK_24M),
		.CYCLE_SLOW  (CYCLE_SLOW),
		.slotPhase   (slotPhase),
		.sprNb       (sprNb),
		.sprTileIdx  (sprTileIdx),
		.fixCol      (fixCol),
		.fixLine     (fixLine),
		.sprBus      (sprBus),
		.fixBus      (fixBus),
		.sprTileNb   (sprTileNb),
		.sprPal      (sprPal),
		.sprAutoAnim (sprAutoAnim),
		.sprFlip     (sprFlip),
		.sprValid    (sprValid),
		.fixTileNb   (fixTileNb),
		.fixPal      (fixPal),
		.fixValid    (fixValid)
	);

endmodule

/* slowVram_assert.sv */
`timescale 1ns/10ps

module slowVramAssert
	import slowVramPkg::*;
(
	input logic      CLK_24M,
	input logic      CYCLE_SLOW,
	input logic      cpuValid,
	input logic      cpuCredit,
	input logic      rdValid,
	input logic      sprValid,
	input logic      fixValid,
	input slotPhaseT slotPhase
);

	int credits;          // Sender credits seen at the pins
	int failCount = 0;    // Read by the testbench at the end

	always_ff @(posedge CLK_24M or posedge CYCLE_SLOW)
	begin
		if (CYCLE_SLOW)
			credits <= CPU_CREDITS;
		else
			credits <= credits + int'(cpuCredit) - int'(cpuValid);
	end

	// Frame steps by one, 7 wraps to 0
	slotOrder: assert property (@(posedge CLK_24M) disable iff (CYCLE_SLOW)
		!$past(CYCLE_SLOW) |-> (slotPhase == slotPhaseT'($past(slotPhase) + 3'd1)))
	else
	begin
		failCount++;
		$error("slot phase left the fixed frame order");
	end

	sprPulse: assert property (@(posedge CLK_24M) disable iff (CYCLE_SLOW)
		sprValid |-> (slotPhase == PH_CPU) ##1 !sprValid)
	else
	begin
		failCount++;
		$error("sprValid not a single pulse in phase 4");
	end

	fixPulse: assert property (@(posedge CLK_24M) disable iff (CYCLE_SLOW)
		fixValid |-> (slotPhase == PH_SPR_A) ##1 !fixValid)
	else
	begin
		failCount++;
		$error("fixValid not a single pulse in phase 0");
	end

	// Credit back in phase 5, read data in phase 6
	creditPulse: assert property (@(posedge CLK_24M) disable iff (CYCLE_SLOW)
		cpuCredit |-> (slotPhase == PH_CPU_RD) ##1 !cpuCredit)
	else
	begin
		failCount++;
		$error("cpuCredit not a single pulse in phase 5");
	end

	rdPulse: assert property (@(posedge CLK_24M) disable iff (CYCLE_SLOW)
		rdValid |-> (slotPhase == 3'd6) ##1 !rdValid)
	else
	begin
		failCount++;
		$error("rdValid not a single pulse in phase 6");
	end

	// A credit returned in this cycle can be spent in the same cycle
	creditRange: assert property (@(posedge CLK_24M) disable iff (CYCLE_SLOW)
		(credits <= CPU_CREDITS) && (!cpuValid || (credits + int'(cpuCredit)) > 0))
	else
	begin
		failCount++;
		$error("credit count out of range");
	end

endmodule

bind slowVramTop slowVramAssert assertInst
(
	.CLK_24M    (CLK_24M),
	.CYCLE_SLOW (CYCLE_SLOW),
	.cpuValid   (cpuValid),
	.cpuCredit  (cpuCredit),
	.rdValid    (rdValid),
	.sprValid   (sprValid),
	.fixValid   (fixValid),
	.slotPhase  (slotPhase)
);

/* spriteFixFetch.sv */
`timescale 1ns/10ps

module spriteFixFetch
	import slowVramPkg::*;
(
	input  logic       CLK_24M,
	input  logic       CYCLE_SLOW,
	input  slotPhaseT  slotPhase,
	input  sprNbT      sprNb,         // Sprite being fetched
	input  sprTileIdxT sprTileIdx,
	input  fixColT     fixCol,
	input  fixLineT    fixLine,
	slowVramIf.client  sprBus,
	slowVramIf.client  fixBus,
	output tileNbT     sprTileNb,
	output logic [7:0] sprPal,
	output logic [1:0] sprAutoAnim,
	output logic [1:0] sprFlip,       // Bit 0 H flip, bit 1 V flip
	output logic       sprValid,
	output fixTileNbT  fixTileNb,
	output logic [3:0] fixPal,
	output logic       fixValid
);

	sprNbT      sprNbQ;        // Held for word B
	sprTileIdxT sprTileIdxQ;
	logic       wordSel;       // 0 word A, 1 word B
	vramDataT   wordA;         // Low tile number

	assign wordSel = (slotPhase >= PH_SPR_B);

	// Live inputs in phase 0, sampled copy afterwards
	assign sprBus.addr = (slotPhase == PH_SPR_A) ?
		{sprNb, sprTileIdx, 1'b0} :
		{sprNbQ, sprTileIdxQ, wordSel};
	assign sprBus.wrData = '0;      // Read-only clients
	assign sprBus.wrEn   = 1'b0;

	// 0 111 0CCC CCCL LLLL, read in phase 6
	assign fixBus.addr   = {FIX_MAP_BASE, fixCol, fixLine};
	assign fixBus.wrData = '0;
	assign fixBus.wrEn   = 1'b0;

	// Sample and decode latches
	always_ff @(posedge CLK_24M)
	begin
		if (slotPhase == PH_SPR_A)
		begin
			sprNbQ      <= sprNb;
			sprTileIdxQ <= sprTileIdx;
		end
		if (slotPhase == PH_SPR_A_LATCH)
			wordA <= sprBus.rdData;
		// Word B on the bus, outputs valid in phase 4
		if (slotPhase == PH_SPR_B_LATCH)
		begin
			sprTileNb   <= {sprBus.rdData[7:4], wordA};
			sprPal      <= sprBus.rdData[15:8];
			sprAutoAnim <= sprBus.rdData[3:2];
			sprFlip     <= sprBus.rdData[1:0];
		end
		if (slotPhase == PH_FIX_LATCH)
		begin
			fixTileNb <= fixBus.rdData[11:0];
			fixPal    <= fixBus.rdData[15:12];    // Valid in phase 0
		end
	end

	// Strobes
	always_ff @(posedge CLK_24M or posedge CYCLE_SLOW)
	begin
		if (CYCLE_SLOW)
		begin
			sprValid <= 1'b0;
			fixValid <= 1'b0;
		end
		else
		begin
			sprValid <= (slotPhase == PH_SPR_B_LATCH);
			fixValid <= (slotPhase == PH_FIX_LATCH);
		end
	end

endmodule
